// File: source/gat_macros.svh
`ifndef GAT_MACROS_SVH
`define GAT_MACROS_SVH

// ============================================================
// Weight matrix geometry
// ============================================================

// Rows of W, one bank entry per row
`define W_ROWS 8

// Columns of W, one bank per column
`define W_COLS 4

// Width of one weight or attention element
`define DATA_WIDTH 8

// Attention vector length, twice the column count
`define A_DEPTH 8

// Receive buffer depth and initial sender credit count
`define CREDITS 4

`endif

// File: source/gat_pkg.sv
`include "gat_macros.svh"

package gat_pkg;

  // One weight or attention coefficient
  typedef logic [`DATA_WIDTH-1:0] weight_t;

  // Beat from the upstream sender
  typedef struct packed {
    logic    valid;
    weight_t data;
  } load_beat_t;

  // Write command to the column banks, col_sel is one-hot
  typedef struct packed {
    logic [`W_COLS-1:0]         col_sel;
    logic [$clog2(`W_ROWS)-1:0] row;
    weight_t                    data;
  } bank_write_t;

  // Write command to the attention register
  typedef struct packed {
    logic                        en;
    logic [$clog2(`A_DEPTH)-1:0] idx;
    weight_t                     data;
  } attn_write_t;

  // Request for one row of W
  typedef struct packed {
    logic                       valid;
    logic [$clog2(`W_ROWS)-1:0] row;
  } row_read_t;

  // One W row across all column banks
  typedef weight_t [`W_COLS-1:0] w_row_t;

  // Whole attention vector
  typedef weight_t [`A_DEPTH-1:0] a_vec_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD_W,
    LOAD_A,
    DONE
  } load_state_t;

endpackage

// File: source/credit_rx_fifo.sv
`include "gat_macros.svh"

module credit_rx_fifo
  import gat_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  load_beat_t beat,
  input  logic       pop,
  output weight_t    head,
  output logic       head_valid,
  output logic       credit_return
);

  localparam int PTR_W = $clog2(`CREDITS);
  localparam int CNT_W = $clog2(`CREDITS + 1);

  weight_t            mem [`CREDITS];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   occupancy;
  logic               push;

  assign push = beat.valid;

  // First word falls through to the head
  assign head       = mem[rd_ptr];
  assign head_valid = (occupancy != '0);

  // Payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= beat.data;
    end
  end

  // ============================================================
  // Pointers, occupancy and credit return
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      occupancy     <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
      // One credit back per popped beat
      credit_return <= pop;
    end
  end

endmodule

// File: source/load_fsm.sv
module load_fsm
  import gat_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        load_start,
  input  logic        head_valid,
  input  logic        last_w,
  input  logic        last_a,
  output logic        pop,
  output logic        step_w,
  output logic        step_a,
  output logic        clear,
  output load_state_t phase,
  output logic        ready
);

  load_state_t state;
  load_state_t state_next;

  assign phase = state;

  // ============================================================
  // Next state and strobes
  // ============================================================
  always_comb begin
    state_next = state;
    pop        = 1'b0;
    step_w     = 1'b0;
    step_a     = 1'b0;
    clear      = 1'b0;
    case (state)
      IDLE, DONE: begin
        // Start only honored between loads
        if (load_start) begin
          clear      = 1'b1;
          state_next = LOAD_W;
        end
      end
      LOAD_W: begin
        pop    = head_valid;
        step_w = head_valid;
        if (head_valid && last_w) begin
          state_next = LOAD_A;
        end
      end
      LOAD_A: begin
        pop    = head_valid;
        step_a = head_valid;
        if (head_valid && last_a) begin
          state_next = DONE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      ready <= 1'b0;
    end else begin
      state <= state_next;
      // High exactly while in DONE
      ready <= (state_next == DONE);
    end
  end

endmodule

// File: source/load_index_counter.sv
`include "gat_macros.svh"

module load_index_counter (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        clear,
  input  logic                        step_w,
  input  logic                        step_a,
  output logic [$clog2(`W_ROWS)-1:0]  row,
  output logic [$clog2(`W_COLS)-1:0]  col,
  output logic [$clog2(`A_DEPTH)-1:0] a_idx,
  output logic                        last_w,
  output logic                        last_a
);

  localparam int ROW_W = $clog2(`W_ROWS);
  localparam int COL_W = $clog2(`W_COLS);
  localparam int IDX_W = $clog2(`A_DEPTH);

  logic col_wrap;
  logic row_wrap;

  assign col_wrap = (col == COL_W'(`W_COLS - 1));
  assign row_wrap = (row == ROW_W'(`W_ROWS - 1));

  // Final element of each phase
  assign last_w = row_wrap && col_wrap;
  assign last_a = (a_idx == IDX_W'(`A_DEPTH - 1));

  // ============================================================
  // Row-major walk over W, then over a
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row   <= '0;
      col   <= '0;
      a_idx <= '0;
    end else if (clear) begin
      row   <= '0;
      col   <= '0;
      a_idx <= '0;
    end else begin
      if (step_w) begin
        col <= col_wrap ? '0 : col + 1'b1;
        // Row moves on when the column wraps
        if (col_wrap) begin
          row <= row_wrap ? '0 : row + 1'b1;
        end
      end
      if (step_a) begin
        a_idx <= last_a ? '0 : a_idx + 1'b1;
      end
    end
  end

endmodule

// File: source/weight_column_bank.sv
`include "gat_macros.svh"

module weight_column_bank
  import gat_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       we,
  input  logic [$clog2(`W_ROWS)-1:0] waddr,
  input  weight_t                    wdata,
  input  logic [$clog2(`W_ROWS)-1:0] raddr,
  output weight_t                    rdata
);

  // One entry per row of W
  weight_t mem [`W_ROWS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, one cycle from address to data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else begin
      rdata <= mem[raddr];
    end
  end

endmodule

// File: source/attn_vector_reg.sv
`include "gat_macros.svh"

module attn_vector_reg
  import gat_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  attn_write_t wr,
  output a_vec_t      a_vec
);

  // ============================================================
  // Attention coefficients, one slot per write
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_vec <= '0;
    end else if (wr.en) begin
      // Only the addressed slot changes
      a_vec[wr.idx] <= wr.data;
    end
  end

endmodule

// File: source/weight_loader.sv
`include "gat_macros.svh"

module weight_loader
  import gat_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load_start,
  input  load_beat_t beat,
  output logic       credit_return,
  input  row_read_t  rd_req,
  output w_row_t     rd_row,
  output logic       rd_valid,
  output a_vec_t     a_vec,
  output logic       ready
);

  weight_t                     head;
  logic                        head_valid;
  logic                        pop;
  logic                        step_w;
  logic                        step_a;
  logic                        clear;
  load_state_t                 phase;
  logic [$clog2(`W_ROWS)-1:0]  row;
  logic [$clog2(`W_COLS)-1:0]  col;
  logic [$clog2(`A_DEPTH)-1:0] a_idx;
  logic                        last_w;
  logic                        last_a;
  bank_write_t                 bank_wr;
  attn_write_t                 attn_wr;

  // ============================================================
  // Receive path and sequencing
  // ============================================================
  credit_rx_fifo rx_fifo_i (
    .clk(clk), .rst_n(rst_n), .beat(beat), .pop(pop),
    .head(head), .head_valid(head_valid), .credit_return(credit_return)
  );

  load_fsm fsm_i (
    .clk(clk), .rst_n(rst_n), .load_start(load_start), .head_valid(head_valid),
    .last_w(last_w), .last_a(last_a), .pop(pop), .step_w(step_w),
    .step_a(step_a), .clear(clear), .phase(phase), .ready(ready)
  );

  load_index_counter counter_i (
    .clk(clk), .rst_n(rst_n), .clear(clear), .step_w(step_w), .step_a(step_a),
    .row(row), .col(col), .a_idx(a_idx), .last_w(last_w), .last_a(last_a)
  );

  // Steer the popped head by phase
  always_comb begin
    bank_wr.col_sel = (pop && phase == LOAD_W) ? (`W_COLS'(1) << col) : '0;
    bank_wr.row     = row;
    bank_wr.data    = head;
    attn_wr.en      = pop && (phase == LOAD_A);
    attn_wr.idx     = a_idx;
    attn_wr.data    = head;
  end

  // ============================================================
  // Column banks and attention vector
  // ============================================================
  for (genvar c = 0; c < `W_COLS; c++) begin : g_bank
    weight_column_bank bank_i (
      .clk(clk), .rst_n(rst_n), .we(bank_wr.col_sel[c]), .waddr(bank_wr.row),
      .wdata(bank_wr.data), .raddr(rd_req.row), .rdata(rd_row[c])
    );
  end

  attn_vector_reg attn_i (.clk(clk), .rst_n(rst_n), .wr(attn_wr), .a_vec(a_vec));

  // Matches the bank read latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_req.valid;
    end
  end

endmodule

// File: tests/weight_loader_properties.sv
`include "gat_macros.svh"

module weight_loader_properties
  import gat_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        beat_valid,
  input logic        pop,
  input logic        credit_return,
  input load_state_t phase,
  input logic        ready
);

  // Shadow of the receive buffer fill level
  int fill;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill <= 0;
    end else begin
      fill <= fill + int'(beat_valid) - int'(pop);
    end
  end

  // ============================================================
  // Flow control and sequencing
  // ============================================================
  occupancy_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    fill <= `CREDITS) else $error("receive buffer holds more than %0d beats", `CREDITS);

  no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> fill > 0) else $error("pop issued while the receive buffer is empty");

  credit_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
    credit_return |-> $past(pop)) else $error("credit returned without a pop before it");

  // ready only in DONE
  ready_not_loading: assert property (@(posedge clk) disable iff (!rst_n)
    (phase == LOAD_W || phase == LOAD_A) |-> !ready) else $error("ready high during a load");

endmodule

// File: tests/weight_loader_tb.sv
`include "gat_macros.svh"

module weight_loader_tb
  import gat_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int ROW_W      = $clog2(`W_ROWS);
  localparam int W_BEATS    = `W_ROWS * `W_COLS;
  localparam int BEATS      = W_BEATS + `A_DEPTH;
  localparam int READ_ROWS  = 4;
  // Two loads and two full readbacks
  localparam int WATCHDOG_CYCLES = 2 * BEATS * 2 + 2 * `W_ROWS * 4 + 200;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        load_start;
  load_beat_t  beat;
  logic        credit_return;
  row_read_t   rd_req;
  w_row_t      rd_row;
  logic        rd_valid;
  a_vec_t      a_vec;
  logic        ready;
  weight_t     patterns [BEATS + READ_ROWS];
  int          credits;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] rng_state;

  bind weight_loader weight_loader_properties props_i (
    .clk(clk), .rst_n(rst_n), .beat_valid(beat.valid), .pop(pop),
    .credit_return(credit_return), .phase(phase), .ready(ready)
  );

  weight_loader weight_loader_i (
    .clk(clk), .rst_n(rst_n), .load_start(load_start), .beat(beat),
    .credit_return(credit_return), .rd_req(rd_req), .rd_row(rd_row),
    .rd_valid(rd_valid), .a_vec(a_vec), .ready(ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // Falling edge, outputs settled; collect returned credits
  task automatic tick();
    @(negedge clk);
    if (credit_return) begin
      credits++;
    end
  endtask

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
    assert (got === expected) else begin
      errors++;
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, errors - test_errors);
    end
  endtask

  // Sender spends one credit per beat, idles at random when gaps is set
  task automatic send_beats(input int first, input int count, input weight_t mask,
                            input bit gaps);
    int next;
    next = first;
    while (next < first + count) begin
      tick();
      beat.valid = 1'b0;
      rng_state  = xorshift32(rng_state);
      if (credits > 0 && !(gaps && rng_state[1:0] == 2'b00)) begin
        beat.valid = 1'b1;
        beat.data  = patterns[next] ^ mask;
        credits--;
        next++;
      end
    end
    tick();
    beat.valid = 1'b0;
  endtask

  task automatic pulse_start();
    load_start = 1'b1;
    tick();
    load_start = 1'b0;
  endtask

  // Ready and the final credit come back right after the last pop
  task automatic wait_load_done();
    int n;
    n = 0;
    while (!(ready && credits == `CREDITS) && n < 100) begin
      tick();
      n++;
    end
    assert (ready) else begin
      errors++;
      $display("Load did not finish, ready still low %0d cycles after the last beat", n);
    end
    expect_equal(credits, `CREDITS, "sender credits after the load");
  endtask

  task automatic read_and_check_row(input int row, input weight_t mask);
    rd_req.valid = 1'b1;
    rd_req.row   = ROW_W'(row);
    tick();
    rd_req.valid = 1'b0;
    expect_equal(32'(rd_valid), 1, $sformatf("rd_valid for row %0d", row));
    for (int c = 0; c < `W_COLS; c++) begin
      expect_equal(32'(rd_row[c]), 32'(patterns[row * `W_COLS + c] ^ mask),
                   $sformatf("row %0d column %0d", row, c));
    end
    tick();
    expect_equal(32'(rd_valid), 0, "rd_valid with no request");
  endtask

  // Listed rows first, then the rows they leave out
  task automatic compare_w_rows(input weight_t mask);
    int order [$];
    bit listed [`W_ROWS];
    for (int r = 0; r < `W_ROWS; r++) begin
      listed[r] = 1'b0;
    end
    for (int i = 0; i < READ_ROWS; i++) begin
      order.push_back(int'(patterns[BEATS + i]));
      listed[order[i]] = 1'b1;
    end
    for (int r = 0; r < `W_ROWS; r++) begin
      if (!listed[r]) begin
        order.push_back(r);
      end
    end
    foreach (order[i]) begin
      read_and_check_row(order[i], mask);
    end
  endtask

  task automatic compare_attention(input weight_t mask);
    for (int k = 0; k < `A_DEPTH; k++) begin
      expect_equal(32'(a_vec[k]), 32'(patterns[W_BEATS + k] ^ mask),
                   $sformatf("a_vec[%0d]", k));
    end
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    rst_n        = 1'b0;
    load_start   = 1'b0;
    beat         = '0;
    rd_req       = '0;
    credits      = `CREDITS;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rng_state    = 32'h425d23f5;
    $readmemh("tests/weight_loader_patterns.txt", patterns);

    // Ten cycles in reset, then one cycle out of it
    test_errors = errors;
    for (int i = 0; i < 11; i++) begin
      tick();
      expect_equal(32'(ready), 0, "ready around reset");
      expect_equal(32'(credit_return), 0, "credit_return around reset");
      expect_equal(32'(rd_valid), 0, "rd_valid around reset");
      if (i == 9) begin
        rst_n = 1'b1;
      end
    end
    finish_test("reset_state");

    test_errors = errors;
    send_beats(0, `CREDITS, 8'h00, 1'b0);
    expect_equal(credits, 0, "sender credits after filling the buffer");
    repeat (20) begin
      tick();
      expect_equal(32'(credit_return), 0, "credit_return while idle");
    end
    expect_equal(credits, 0, "sender credits while stalled");
    finish_test("back_pressure");

    test_errors = errors;
    pulse_start();
    send_beats(`CREDITS, BEATS - `CREDITS, 8'h00, 1'b1);
    wait_load_done();
    finish_test("full_load");

    test_errors = errors;
    compare_w_rows(8'h00);
    finish_test("w_layout");

    test_errors = errors;
    compare_attention(8'h00);
    finish_test("attention_vector");

    // Second load over the first, every beat changed
    test_errors = errors;
    pulse_start();
    expect_equal(32'(ready), 0, "ready after load_start in DONE");
    send_beats(0, BEATS, 8'h5a, 1'b1);
    wait_load_done();
    compare_w_rows(8'h5a);
    compare_attention(8'h5a);
    finish_test("reload");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("Timeout: the run was still going after %0d cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

// File: tests/weight_loader_patterns.txt
// W rows: one line per row of W, columns 0 to 3, beats sent row-major
// Then 8 attention beats a[0..7], then 4 row indices for the readback order
3c a7 11 e4
58 9b 02 f0
6d c1 37 8a
b5 4e 93 2f
71 0d cc 66
e9 15 a2 7b
40 d8 5f 24
8e b3 19 f6
07 c4 5b 92 3e e1 68 ad
05 02 07 00

// File: sources.f
+incdir+source
source/gat_pkg.sv
source/credit_rx_fifo.sv
source/load_fsm.sv
source/load_index_counter.sv
source/weight_column_bank.sv
source/attn_vector_reg.sv
source/weight_loader.sv
tests/weight_loader_properties.sv
tests/weight_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the weight loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module weight_loader_tb -f sources.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_output=$(./obj_dir/Vweight_loader_tb); then
  printf '%s\n' "$sim_output"
  echo "Simulation exited with an error status"
  exit 1
fi
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qx "test passed"; then
  exit 0
fi
exit 1
